//--- hw/rs_consts.svh
/*
 * reservation station constants
 * entry count and field widths for the package and the RTL
 */

`ifndef RS_CONSTS_SVH
`define RS_CONSTS_SVH

// station depth and the index that addresses it
`define RS_ENTRIES 8
`define RS_INDEX_WIDTH 3

// reorder buffer tag, zero means no wait
`define RS_TAG_WIDTH 4

// operand value
`define RS_DATA_WIDTH 32

// operation code passed through to the functional unit
`define RS_OP_WIDTH 4

`endif

//--- hw/rs_pkg.sv
/*
 * reservation station types
 * vector typedefs for tags, values, opcodes, masks and credits,
 * plus the state encoding of one station entry
 */

`default_nettype none

`include "rs_consts.svh"

package rs_pkg;

    // field vectors
    typedef logic [`RS_TAG_WIDTH-1:0]   rs_tag_t;
    typedef logic [`RS_DATA_WIDTH-1:0]  rs_data_t;
    typedef logic [`RS_OP_WIDTH-1:0]    rs_op_t;
    typedef logic [`RS_INDEX_WIDTH-1:0] rs_index_t;

    // one bit per entry: load, busy, ready, grant
    typedef logic [`RS_ENTRIES-1:0]     rs_mask_t;

    // 0 to RS_ENTRIES credits, one extra bit
    typedef logic [`RS_INDEX_WIDTH:0]   rs_credit_t;

    typedef enum logic [1:0] {ENTRY_FREE, ENTRY_WAIT, ENTRY_READY} entry_state_e;

endpackage

`default_nettype wire

//--- hw/rs_dispatch.sv
/*
 * dispatch control
 * steers a new instruction into the lowest free entry, returns one
 * credit per freed entry, flags a dispatch that found no room
 */

`timescale 1ns/1ps
`default_nettype none

`include "rs_consts.svh"

module rs_dispatch (
    input  logic             clock,
    input  logic             reset,
    input  logic             dispatch_valid,
    input  rs_pkg::rs_mask_t entry_busy,
    input  rs_pkg::rs_mask_t entry_grant,
    output rs_pkg::rs_mask_t entry_load,
    output logic             credit_return,
    output logic             dispatch_overflow
);
    import rs_pkg::*;

    rs_mask_t free_mask;
    logic     slot_found;

    assign free_mask = ~entry_busy;

    // lowest free entry wins, only one load bit at a time
    always_comb begin
        entry_load = '0;
        slot_found = 1'b0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (!slot_found && free_mask[i]) begin
                slot_found    = 1'b1;
                entry_load[i] = dispatch_valid;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // credits and overflow
    ////////////////////////////////////////////////////////////

    // granted entry frees at the next edge, credit goes back then
    always_ff @(posedge clock) begin
        if (reset) begin
            credit_return     <= 1'b0;
            dispatch_overflow <= 1'b0;
        end else begin
            credit_return <= |entry_grant;
            // sticky, sender dispatched without a credit
            if (dispatch_valid && !slot_found)
                dispatch_overflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/rs_entry.sv
/*
 * one reservation station entry
 * holds an instruction until both operands are known, snoops the
 * data bus for pending tags and reports ready to the issue select
 */

`timescale 1ns/1ps
`default_nettype none

module rs_entry (
    input  logic             clock,
    input  logic             reset,
    input  logic             load,
    input  logic             grant,
    input  rs_pkg::rs_op_t   dispatch_op,
    input  rs_pkg::rs_tag_t  dispatch_dest,
    input  rs_pkg::rs_tag_t  dispatch_src1_tag,
    input  rs_pkg::rs_data_t dispatch_src1_value,
    input  rs_pkg::rs_tag_t  dispatch_src2_tag,
    input  rs_pkg::rs_data_t dispatch_src2_value,
    input  logic             cdb_valid,
    input  rs_pkg::rs_tag_t  cdb_tag,
    input  rs_pkg::rs_data_t cdb_value,
    output logic             busy,
    output logic             ready,
    output rs_pkg::rs_op_t   entry_op,
    output rs_pkg::rs_tag_t  entry_dest,
    output rs_pkg::rs_data_t entry_src1_value,
    output rs_pkg::rs_data_t entry_src2_value
);
    import rs_pkg::*;

    entry_state_e state;
    rs_tag_t      src1_tag;
    rs_tag_t      src2_tag;

    // data bus hits on the incoming dispatch fields
    logic load1_hit;
    logic load2_hit;
    // data bus hits on the held tags
    logic wait1_hit;
    logic wait2_hit;

    assign load1_hit = cdb_valid && (dispatch_src1_tag != '0) && (cdb_tag == dispatch_src1_tag);
    assign load2_hit = cdb_valid && (dispatch_src2_tag != '0) && (cdb_tag == dispatch_src2_tag);
    assign wait1_hit = cdb_valid && (state == ENTRY_WAIT) && (src1_tag != '0)
                       && (cdb_tag == src1_tag);
    assign wait2_hit = cdb_valid && (state == ENTRY_WAIT) && (src2_tag != '0)
                       && (cdb_tag == src2_tag);

    assign busy  = (state != ENTRY_FREE);
    assign ready = (state == ENTRY_READY);

    ////////////////////////////////////////////////////////////
    // entry state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ENTRY_FREE;
        end else begin
            case (state)
                ENTRY_FREE:
                    if (load) begin
                        // ready right away if nothing is left to wait on
                        if ((dispatch_src1_tag == '0 || load1_hit) &&
                            (dispatch_src2_tag == '0 || load2_hit))
                            state <= ENTRY_READY;
                        else
                            state <= ENTRY_WAIT;
                    end
                ENTRY_WAIT:
                    if ((src1_tag == '0 || wait1_hit) && (src2_tag == '0 || wait2_hit))
                        state <= ENTRY_READY;
                // granted entry frees at the next edge
                ENTRY_READY:
                    if (grant)
                        state <= ENTRY_FREE;
                default:
                    state <= ENTRY_FREE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // payload, written on load or on a bus match
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (load) begin
            entry_op         <= dispatch_op;
            entry_dest       <= dispatch_dest;
            src1_tag         <= load1_hit ? '0 : dispatch_src1_tag;
            src2_tag         <= load2_hit ? '0 : dispatch_src2_tag;
            entry_src1_value <= load1_hit ? cdb_value : dispatch_src1_value;
            entry_src2_value <= load2_hit ? cdb_value : dispatch_src2_value;
        end else begin
            if (wait1_hit) begin
                src1_tag         <= '0;
                entry_src1_value <= cdb_value;
            end
            if (wait2_hit) begin
                src2_tag         <= '0;
                entry_src2_value <= cdb_value;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rs_issue_select.sv
/*
 * issue select
 * round-robin pick of one ready entry per cycle, drives its fields
 * to the functional unit and its grant back to the entries
 */

`timescale 1ns/1ps
`default_nettype none

`include "rs_consts.svh"

module rs_issue_select (
    input  logic                                 clock,
    input  logic                                 reset,
    input  rs_pkg::rs_mask_t                     entry_ready,
    input  rs_pkg::rs_op_t   [`RS_ENTRIES-1:0]   entry_op,
    input  rs_pkg::rs_tag_t  [`RS_ENTRIES-1:0]   entry_dest,
    input  rs_pkg::rs_data_t [`RS_ENTRIES-1:0]   entry_src1_value,
    input  rs_pkg::rs_data_t [`RS_ENTRIES-1:0]   entry_src2_value,
    output rs_pkg::rs_mask_t                     entry_grant,
    output logic                                 issue_valid,
    output rs_pkg::rs_op_t                       issue_op,
    output rs_pkg::rs_tag_t                      issue_dest,
    output rs_pkg::rs_data_t                     issue_src1_value,
    output rs_pkg::rs_data_t                     issue_src2_value
);
    import rs_pkg::*;

    rs_index_t rr_ptr;
    rs_index_t scan_index;
    rs_index_t grant_index;
    logic      grant_found;

    // first ready entry at or after the pointer
    // index wraps on its own, entry count is a power of two
    always_comb begin
        grant_found = 1'b0;
        grant_index = rr_ptr;
        scan_index  = rr_ptr;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            scan_index = rr_ptr + rs_index_t'(i);
            if (!grant_found && entry_ready[scan_index]) begin
                grant_found = 1'b1;
                grant_index = scan_index;
            end
        end
    end

    assign entry_grant = grant_found ? (rs_mask_t'(1) << grant_index) : '0;

    // issue port, straight from the winning entry's registers
    assign issue_valid      = grant_found;
    assign issue_op         = entry_op[grant_index];
    assign issue_dest       = entry_dest[grant_index];
    assign issue_src1_value = entry_src1_value[grant_index];
    assign issue_src2_value = entry_src2_value[grant_index];

    // pointer moves one past the winner
    always_ff @(posedge clock) begin
        if (reset)
            rr_ptr <= '0;
        else if (grant_found)
            rr_ptr <= grant_index + rs_index_t'(1);
    end

endmodule

`default_nettype wire

//--- hw/rs_top.sv
/*
 * reservation station top
 * dispatch control, the entry array and the issue select
 */

`timescale 1ns/1ps
`default_nettype none

`include "rs_consts.svh"

module rs_top (
    input  logic             clock,
    input  logic             reset,
    input  logic             dispatch_valid,
    input  rs_pkg::rs_op_t   dispatch_op,
    input  rs_pkg::rs_tag_t  dispatch_dest,
    input  rs_pkg::rs_tag_t  dispatch_src1_tag,
    input  rs_pkg::rs_data_t dispatch_src1_value,
    input  rs_pkg::rs_tag_t  dispatch_src2_tag,
    input  rs_pkg::rs_data_t dispatch_src2_value,
    input  logic             cdb_valid,
    input  rs_pkg::rs_tag_t  cdb_tag,
    input  rs_pkg::rs_data_t cdb_value,
    output logic             issue_valid,
    output rs_pkg::rs_op_t   issue_op,
    output rs_pkg::rs_tag_t  issue_dest,
    output rs_pkg::rs_data_t issue_src1_value,
    output rs_pkg::rs_data_t issue_src2_value,
    output logic             credit_return,
    output logic             dispatch_overflow
);
    import rs_pkg::*;

    // per-entry control
    rs_mask_t entry_load;
    rs_mask_t entry_busy;
    rs_mask_t entry_ready;
    rs_mask_t entry_grant;

    // per-entry fields toward issue select
    rs_op_t   [`RS_ENTRIES-1:0] entry_op;
    rs_tag_t  [`RS_ENTRIES-1:0] entry_dest;
    rs_data_t [`RS_ENTRIES-1:0] entry_src1_value;
    rs_data_t [`RS_ENTRIES-1:0] entry_src2_value;

    rs_dispatch u_dispatch (
        .clock             (clock),
        .reset             (reset),
        .dispatch_valid    (dispatch_valid),
        .entry_busy        (entry_busy),
        .entry_grant       (entry_grant),
        .entry_load        (entry_load),
        .credit_return     (credit_return),
        .dispatch_overflow (dispatch_overflow)
    );

    ////////////////////////////////////////////////////////////
    // entry array, dispatch fields and data bus are shared
    ////////////////////////////////////////////////////////////
    for (genvar g = 0; g < `RS_ENTRIES; g++) begin : g_entry
        rs_entry u_entry (
            .clock               (clock),
            .reset               (reset),
            .load                (entry_load[g]),
            .grant               (entry_grant[g]),
            .dispatch_op         (dispatch_op),
            .dispatch_dest       (dispatch_dest),
            .dispatch_src1_tag   (dispatch_src1_tag),
            .dispatch_src1_value (dispatch_src1_value),
            .dispatch_src2_tag   (dispatch_src2_tag),
            .dispatch_src2_value (dispatch_src2_value),
            .cdb_valid           (cdb_valid),
            .cdb_tag             (cdb_tag),
            .cdb_value           (cdb_value),
            .busy                (entry_busy[g]),
            .ready               (entry_ready[g]),
            .entry_op            (entry_op[g]),
            .entry_dest          (entry_dest[g]),
            .entry_src1_value    (entry_src1_value[g]),
            .entry_src2_value    (entry_src2_value[g])
        );
    end

    rs_issue_select u_issue_select (
        .clock            (clock),
        .reset            (reset),
        .entry_ready      (entry_ready),
        .entry_op         (entry_op),
        .entry_dest       (entry_dest),
        .entry_src1_value (entry_src1_value),
        .entry_src2_value (entry_src2_value),
        .entry_grant      (entry_grant),
        .issue_valid      (issue_valid),
        .issue_op         (issue_op),
        .issue_dest       (issue_dest),
        .issue_src1_value (issue_src1_value),
        .issue_src2_value (issue_src2_value)
    );

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
/*
 * testbench clock and reset
 * 20 ns clock, reset held high for the first 4 rising edges
 */

`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // release on a falling edge, clear of the rising edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/rs_tb.sv
/*
 * reservation station testbench
 * table of dispatch and data bus traffic, checked every cycle against
 * a reference model of the entries and the round-robin issue order
 */

`timescale 1ns/1ps
`default_nettype none

`include "rs_consts.svh"

module rs_tb;
    import rs_pkg::*;

    // one table row is one cycle of inputs plus the dest expected on issue
    typedef struct packed {
        logic [3:0] test;
        logic       dv;
        rs_op_t     op;
        rs_tag_t    dest;
        rs_tag_t    t1;
        rs_data_t   v1;
        rs_tag_t    t2;
        rs_data_t   v2;
        logic       cv;
        rs_tag_t    ctag;
        rs_data_t   cval;
        rs_tag_t    exp_dest;
    } row_t;

    logic     clock;
    logic     reset;
    logic     dispatch_valid;
    rs_op_t   dispatch_op;
    rs_tag_t  dispatch_dest;
    rs_tag_t  dispatch_src1_tag;
    rs_data_t dispatch_src1_value;
    rs_tag_t  dispatch_src2_tag;
    rs_data_t dispatch_src2_value;
    logic     cdb_valid;
    rs_tag_t  cdb_tag;
    rs_data_t cdb_value;
    logic     issue_valid;
    rs_op_t   issue_op;
    rs_tag_t  issue_dest;
    rs_data_t issue_src1_value;
    rs_data_t issue_src2_value;
    logic     credit_return;
    logic     dispatch_overflow;

    // reference model of the entry array
    logic     m_busy  [`RS_ENTRIES] = '{default: 1'b0};
    logic     m_ready [`RS_ENTRIES] = '{default: 1'b0};
    rs_tag_t  m_tag1  [`RS_ENTRIES];
    rs_tag_t  m_tag2  [`RS_ENTRIES];
    rs_data_t m_val1  [`RS_ENTRIES];
    rs_data_t m_val2  [`RS_ENTRIES];
    rs_op_t   m_op    [`RS_ENTRIES];
    rs_tag_t  m_dest  [`RS_ENTRIES];
    int       m_ptr = 0;
    logic     m_credit = 1'b0;
    logic     m_overflow = 1'b0;

    row_t       table_rows [$];
    rs_credit_t credits;
    integer     seed = 32'ha69e_56b3;
    int         checks = 0;
    int         errors = 0;
    int         errors_base = 0;
    int         issue_count = 0;
    int         credit_pulses = 0;
    int         cycle_count = 0;
    int         cycle_limit = 40;
    string      test_names [6] = '{"", "issue without wait", "wait then broadcast",
                                   "broadcast at dispatch", "round-robin wakeup",
                                   "fill and overflow"};

    clock_gen clock_gen_i (.clock(clock), .reset(reset));

    rs_top UUT (.*);

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////
    task automatic tally(input string name, input logic ok, input logic [31:0] exp,
                         input logic [31:0] act);
        checks++;
        if (!ok) begin
            errors++;
            $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_op(input string name, input rs_op_t exp, input rs_op_t act);
        tally(name, act === exp, 32'(exp), 32'(act));
    endtask

    task automatic check_tag(input string name, input rs_tag_t exp, input rs_tag_t act);
        tally(name, act === exp, 32'(exp), 32'(act));
    endtask

    task automatic check_data(input string name, input rs_data_t exp, input rs_data_t act);
        tally(name, act === exp, exp, act);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        tally(name, act === exp, 32'(exp), 32'(act));
    endtask

    task automatic check_credit(input string name, input rs_credit_t exp, input rs_credit_t act);
        tally(name, act === exp, 32'(exp), 32'(act));
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // first ready entry at or after the pointer or -1 when none is ready
    function automatic int pick_ready();
        int idx;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            idx = (m_ptr + i) % `RS_ENTRIES;
            if (m_ready[idx])
                return idx;
        end
        return -1;
    endfunction

    function automatic logic model_busy();
        logic any;
        any = 1'b0;
        for (int e = 0; e < `RS_ENTRIES; e++)
            any = any | m_busy[e];
        return any;
    endfunction

    // what one rising edge does to the station with these inputs
    task automatic model_step(input row_t r);
        int   g;
        int   slot;
        logic hit1;
        logic hit2;
        g = pick_ready();
        slot = -1;
        // lowest free entry as seen before the edge
        for (int e = `RS_ENTRIES - 1; e >= 0; e--)
            if (!m_busy[e])
                slot = e;
        m_credit = (g >= 0);
        if (r.dv && slot < 0)
            m_overflow = 1'b1;
        // waiting entries snoop the bus
        for (int e = 0; e < `RS_ENTRIES; e++) begin
            if (m_busy[e] && !m_ready[e] && r.cv) begin
                if (m_tag1[e] != '0 && m_tag1[e] == r.ctag) begin
                    m_tag1[e] = '0;
                    m_val1[e] = r.cval;
                end
                if (m_tag2[e] != '0 && m_tag2[e] == r.ctag) begin
                    m_tag2[e] = '0;
                    m_val2[e] = r.cval;
                end
            end
            m_ready[e] = m_busy[e] && m_tag1[e] == '0 && m_tag2[e] == '0;
        end
        if (g >= 0) begin
            m_busy[g]  = 1'b0;
            m_ready[g] = 1'b0;
            m_ptr      = (g + 1) % `RS_ENTRIES;
        end
        if (r.dv && slot >= 0) begin
            hit1          = r.cv && r.t1 != '0 && r.t1 == r.ctag;
            hit2          = r.cv && r.t2 != '0 && r.t2 == r.ctag;
            m_busy[slot]  = 1'b1;
            m_op[slot]    = r.op;
            m_dest[slot]  = r.dest;
            m_tag1[slot]  = hit1 ? '0 : r.t1;
            m_tag2[slot]  = hit2 ? '0 : r.t2;
            m_val1[slot]  = hit1 ? r.cval : r.v1;
            m_val2[slot]  = hit2 ? r.cval : r.v2;
            m_ready[slot] = (m_tag1[slot] == '0) && (m_tag2[slot] == '0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////
    task automatic add_row(input int test, input logic dv, input int op, input int dest,
                           input int t1, input rs_data_t v1, input int t2, input rs_data_t v2,
                           input int exp_dest);
        row_t r;
        r          = '0;
        r.test     = 4'(test);
        r.dv       = dv;
        r.op       = rs_op_t'(op);
        r.dest     = rs_tag_t'(dest);
        r.t1       = rs_tag_t'(t1);
        r.t2       = rs_tag_t'(t2);
        // a waiting source carries junk the station must ignore
        r.v1       = (t1 != 0) ? rs_data_t'($random(seed)) : v1;
        r.v2       = (t2 != 0) ? rs_data_t'($random(seed)) : v2;
        r.exp_dest = rs_tag_t'(exp_dest);
        table_rows.push_back(r);
    endtask

    task automatic dispatch_row(input int test, input int op, input int dest, input int t1,
                                input rs_data_t v1, input int t2, input rs_data_t v2);
        add_row(test, 1'b1, op, dest, t1, v1, t2, v2, 0);
    endtask

    task automatic idle_row(input int test, input int exp_dest);
        add_row(test, 1'b0, 0, 0, 0, '0, 0, '0, exp_dest);
    endtask

    // bus broadcast in the same cycle as the last row
    task automatic with_bus(input int tag, input rs_data_t value);
        row_t r;
        r      = table_rows.pop_back();
        r.cv   = 1'b1;
        r.ctag = rs_tag_t'(tag);
        r.cval = value;
        table_rows.push_back(r);
    endtask

    task automatic build_table();
        // both sources ready so it issues the next cycle
        idle_row(1, 0);
        dispatch_row(1, 3, 1, 0, 32'h0000_0011, 0, 32'h0000_0022);
        idle_row(1, 1);
        idle_row(1, 0);
        // src1 waits on tag 7 and a later src2 on tag 8
        dispatch_row(2, 5, 2, 7, '0, 0, 32'h0000_0044);
        idle_row(2, 0);
        idle_row(2, 0);
        idle_row(2, 0);
        with_bus(7, 32'haaaa_0007);
        idle_row(2, 2);
        dispatch_row(2, 6, 3, 0, 32'h0000_0055, 8, '0);
        idle_row(2, 0);
        with_bus(8, 32'hbbbb_0008);
        idle_row(2, 3);
        idle_row(2, 0);
        // tag on the bus in the dispatch cycle
        dispatch_row(3, 7, 4, 9, '0, 0, 32'h0000_0066);
        with_bus(9, 32'hcccc_0009);
        idle_row(3, 4);
        dispatch_row(3, 8, 5, 0, 32'h0000_0077, 11, '0);
        with_bus(11, 32'hdddd_000b);
        idle_row(3, 5);
        idle_row(3, 0);
        // three wait on tag 12 while the pointer sits at entry 1
        dispatch_row(4, 1, 6, 12, '0, 0, 32'h0000_0001);
        dispatch_row(4, 2, 7, 0, 32'h0000_0002, 12, '0);
        dispatch_row(4, 4, 8, 12, '0, 12, '0);
        idle_row(4, 0);
        with_bus(12, 32'heeee_000c);
        idle_row(4, 7);
        idle_row(4, 8);
        idle_row(4, 6);
        idle_row(4, 0);
        // fill all eight and send a ninth without a credit
        for (int i = 0; i < `RS_ENTRIES; i++)
            dispatch_row(5, i + 1, 8 + i, 13, '0, 0, 32'h0000_0100 + i);
        dispatch_row(5, 9, 2, 0, 32'h0000_0005, 0, 32'h0000_0006);
        idle_row(5, 0);
        idle_row(5, 0);
        with_bus(13, 32'h1234_0013);
        for (int i = 1; i <= `RS_ENTRIES; i++)
            idle_row(5, 8 + (i % `RS_ENTRIES));
        idle_row(5, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // one cycle checks the outputs and then drives the next inputs
    ////////////////////////////////////////////////////////////
    task automatic drive_inputs(input row_t r);
        dispatch_valid      = r.dv;
        dispatch_op         = r.op;
        dispatch_dest       = r.dest;
        dispatch_src1_tag   = r.t1;
        dispatch_src1_value = r.v1;
        dispatch_src2_tag   = r.t2;
        dispatch_src2_value = r.v2;
        cdb_valid           = r.cv;
        cdb_tag             = r.ctag;
        cdb_value           = r.cval;
    endtask

    task automatic run_cycle(input row_t r, input logic use_table);
        int g;
        @(negedge clock);
        g = pick_ready();
        check_bit("issue_valid", g >= 0, issue_valid);
        if (g >= 0) begin
            check_op("issue_op", m_op[g], issue_op);
            check_tag("issue_dest", m_dest[g], issue_dest);
            check_data("issue_src1_value", m_val1[g], issue_src1_value);
            check_data("issue_src2_value", m_val2[g], issue_src2_value);
        end
        if (use_table)
            check_tag("issue_dest from table", r.exp_dest, issue_valid ? issue_dest : '0);
        check_bit("credit_return", m_credit, credit_return);
        check_bit("dispatch_overflow", m_overflow, dispatch_overflow);
        if (issue_valid)
            issue_count++;
        // sender side credit counter
        if (credit_return) begin
            credit_pulses++;
            credits = credits + 1'b1;
        end
        if (r.dv) begin
            if (credits != '0)
                credits = credits - 1'b1;
            else
                $display("%0t: dispatch sent without a credit", $time);
        end
        drive_inputs(r);
        model_step(r);
    endtask

    task automatic report_test(input int test);
        $display("test %0d %s: %s", test, test_names[test],
                 (errors == errors_base) ? "passed" : "failed");
        errors_base = errors;
    endtask

    // run limit from the table length
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout, the run did not end within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        drive_inputs('0);
        credits = rs_credit_t'(`RS_ENTRIES);
        build_table();
        cycle_limit = table_rows.size() + 40;
        // whole reset pulse, rise and then release
        wait (reset === 1'b1);
        wait (reset === 1'b0);
        for (int r = 0; r < table_rows.size(); r++) begin
            run_cycle(table_rows[r], 1'b1);
            if (r + 1 < table_rows.size() && table_rows[r + 1].test != table_rows[r].test)
                report_test(int'(table_rows[r].test));
        end
        // wait for the last issues and credits to drain
        while (issue_valid || credit_return || model_busy())
            run_cycle('0, 1'b0);
        check_credit("credits held", rs_credit_t'(`RS_ENTRIES), credits);
        if (credit_pulses != issue_count) begin
            errors++;
            $display("credit_return pulsed %0d times for %0d issues", credit_pulses,
                     issue_count);
        end
        report_test(int'(table_rows[table_rows.size() - 1].test));
        $display("%0d checks, %0d errors, %0d issues, %0d credits returned", checks, errors,
                 issue_count, credit_pulses);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/rs_pkg.sv
hw/rs_dispatch.sv
hw/rs_entry.sv
hw/rs_issue_select.sv
hw/rs_top.sv
bench/clock_gen.sv
bench/rs_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the reservation station testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module rs_tb -Mdir obj_dir -o rs_sim \
    && ./obj_dir/rs_sim 2>&1 | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "RESULT: FAIL" sim.log && { echo "simulation reported a failure"; exit 1; }
echo "simulation finished without failures"
exit 0
